//--- design/cardiac_config.svh
`ifndef CARDIAC_CONFIG_SVH
`define CARDIAC_CONFIG_SVH

// sizing of the decimal machine

// words of main memory, cells 00 through 99
`define CARDIAC_MEM_WORDS 100

// instruction queue entries; fetch starts with this many credits
`define CARDIAC_QUEUE_DEPTH 4

// two BCD digits per address
`define CARDIAC_ADDR_BITS 8

`endif

//--- design/cardiacPkg.sv
`include "cardiac_config.svh"
`default_nettype none

package cardiacPkg;

   typedef logic [3:0] bcdDigit_t; // one decimal digit, 0..9

   // memory word: sign and three digits, 13 bits
   typedef struct packed {
      logic sign;              // 1 = negative
      bcdDigit_t [2:0] digits; // digits[2] is the hundreds digit
   } cardiacWord_t;

   // accumulator: sign and four digits, 17 bits
   typedef struct packed {
      logic sign;
      bcdDigit_t [3:0] digits;
   } accWord_t;

   typedef enum logic [3:0] {
      INP = 4'd0,
      CLA = 4'd1,
      ADD = 4'd2,
      TAC = 4'd3,
      SFT = 4'd4,
      OUT = 4'd5,
      STO = 4'd6,
      SUB = 4'd7,
      JMP = 4'd8,
      HRS = 4'd9
   } opcode_t;

   // one decoded instruction word as it sits in the queue
   typedef struct packed {
      opcode_t op;
      logic [`CARDIAC_ADDR_BITS-1:0] addr; // operand, two BCD digits
   } instrEntry_t;

   // 0..depth credits
   typedef logic [$clog2(`CARDIAC_QUEUE_DEPTH+1)-1:0] credit_t;

   typedef enum logic {
      FETCH_IDLE,
      FETCH_RUN
   } fetchState_t;

   typedef enum logic [2:0] {
      EXEC_IDLE,
      EXEC_DECODE,
      EXEC_OPERAND,
      EXEC_WRITEBACK,
      EXEC_HALTED
   } execState_t;

endpackage

`default_nettype wire

//--- design/wordMemory.sv
`include "cardiac_config.svh"
`timescale 1ns/1ps
`default_nettype none

module wordMemory
   import cardiacPkg::*;
(
   input  wire logic                          clk1,
   input  wire logic [`CARDIAC_ADDR_BITS-1:0] fetchAddr,
   output cardiacWord_t                       fetchData,
   input  wire logic [`CARDIAC_ADDR_BITS-1:0] execAddr,
   input  wire logic                          execWrite,
   input  wire cardiacWord_t                  execWrData,
   output cardiacWord_t                       execRdData,
   input  wire logic                          loadEn,
   input  wire logic [`CARDIAC_ADDR_BITS-1:0] loadAddr,
   input  wire cardiacWord_t                  loadData
);

   cardiacWord_t mem [`CARDIAC_MEM_WORDS]; // cells 00..99

   logic [`CARDIAC_ADDR_BITS-1:0] portAddr; // shared exec/load port
   logic portWrite;
   cardiacWord_t portWrData;

   // two BCD digits to a linear cell number
   function automatic int bcdIndex(input logic [`CARDIAC_ADDR_BITS-1:0] a);
      return int'(a[7:4]) * 10 + int'(a[3:0]);
   endfunction

   // loader owns the port while loadEn is high
   assign portAddr = loadEn ? loadAddr : execAddr;
   assign portWrite = loadEn || execWrite;
   assign portWrData = loadEn ? loadData : execWrData;

   always_ff @(posedge clk1)
   begin
      if (portWrite)
         mem[bcdIndex(portAddr)] <= portWrData; // lands at the edge
      fetchData <= mem[bcdIndex(fetchAddr)];   // one cycle read
      execRdData <= mem[bcdIndex(portAddr)];
   end

   // a bad BCD digit would land outside 00..99
   assert property (@(posedge clk1) portWrite |-> bcdIndex(portAddr) < `CARDIAC_MEM_WORDS)
      else $error("wordMemory: write to cell %0d", bcdIndex(portAddr));

endmodule

`default_nettype wire

//--- design/fetchSequencer.sv
`include "cardiac_config.svh"
`timescale 1ns/1ps
`default_nettype none

module fetchSequencer
   import cardiacPkg::*;
(
   input  wire logic                          clk1,
   input  wire logic                          reset,
   input  wire logic                          start,
   input  wire logic                          redirect,
   input  wire logic [`CARDIAC_ADDR_BITS-1:0] redirectAddr,
   input  wire logic                          creditReturn,
   output logic [`CARDIAC_ADDR_BITS-1:0]      fetchAddr,
   input  wire cardiacWord_t                  fetchData,
   output logic                               push,
   output instrEntry_t                        pushEntry
);

   localparam credit_t fullCredits = credit_t'(`CARDIAC_QUEUE_DEPTH);

   fetchState_t state;
   logic [`CARDIAC_ADDR_BITS-1:0] pc; // the bug
   credit_t credits;                  // free queue slots we may still fill
   logic readPending;                 // read issued last cycle, word arrives now
   logic issue;

   // decimal +1, 99 wraps to 00
   function automatic logic [`CARDIAC_ADDR_BITS-1:0] bcdIncr(
      input logic [`CARDIAC_ADDR_BITS-1:0] v
   );
      if (v[3:0] != 4'd9)
         return {v[7:4], v[3:0] + 4'd1};
      else if (v[7:4] != 4'd9)
         return {v[7:4] + 4'd1, 4'd0};
      else
         return '0;
   endfunction

   // keep one credit back for a read still in flight
   assign issue = (state == FETCH_RUN) && !start && !redirect
                  && (credits > credit_t'(readPending));

   assign fetchAddr = pc;
   assign push = readPending; // word is back, hand it to the queue
   assign pushEntry.op = opcode_t'(fetchData.digits[2]); // top digit is the opcode
   assign pushEntry.addr = {fetchData.digits[1], fetchData.digits[0]};

   always_ff @(posedge clk1)
   begin
      if (!reset)
      begin
         state <= FETCH_IDLE;
         pc <= '0;
         credits <= fullCredits;
         readPending <= 1'b0;
      end
      else if (start || redirect)
      begin
         if (start)
            state <= FETCH_RUN;
         pc <= start ? '0 : redirectAddr;
         credits <= fullCredits;  // queue is flushed in this same cycle
         readPending <= 1'b0;     // drop the read in flight
      end
      else
      begin
         readPending <= issue;
         if (issue)
            pc <= bcdIncr(pc);
         credits <= credits - credit_t'(push) + credit_t'(creditReturn);
      end
   end

   assert property (@(posedge clk1) disable iff (!reset) credits <= fullCredits)
      else $error("fetchSequencer: %0d credits", credits);

   // queue has no ready, a credit must back every push
   assert property (@(posedge clk1) disable iff (!reset) push |-> credits != '0)
      else $error("fetchSequencer: push without credit");

endmodule

`default_nettype wire

//--- design/instrQueue.sv
`include "cardiac_config.svh"
`timescale 1ns/1ps
`default_nettype none

module instrQueue
   import cardiacPkg::*;
#(
   parameter int depth = `CARDIAC_QUEUE_DEPTH
)
(
   input  wire logic        clk1,
   input  wire logic        reset,
   input  wire logic        push,
   input  wire instrEntry_t pushEntry,
   input  wire logic        pop,
   output instrEntry_t      popEntry,
   output logic             notEmpty,
   input  wire logic        flush,
   output logic             creditReturn
);

   localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;

   instrEntry_t entries [depth];
   logic [ptrBits-1:0] wrPtr;
   logic [ptrBits-1:0] rdPtr;
   logic [ptrBits:0] count; // occupancy, 0..depth
   logic doPush;
   logic doPop;

   // circular wrap for any depth
   function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] p);
      return (p == ptrBits'(depth - 1)) ? '0 : p + 1'b1;
   endfunction

   assign doPush = push && !flush; // flush wins over a same cycle push
   assign doPop = pop && notEmpty && !flush;
   assign notEmpty = (count != '0);
   assign popEntry = entries[rdPtr]; // head, valid with notEmpty

   always_ff @(posedge clk1)
   begin
      if (doPush)
         entries[wrPtr] <= pushEntry;
   end

   always_ff @(posedge clk1)
   begin
      if (!reset)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
         creditReturn <= 1'b0;
      end
      else
      begin
         creditReturn <= doPop; // one slot freed per pop, a cycle later
         if (flush)
         begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
         end
         else
         begin
            if (doPush)
               wrPtr <= nextPtr(wrPtr);
            if (doPop)
               rdPtr <= nextPtr(rdPtr);
            count <= count + (ptrBits+1)'(doPush) - (ptrBits+1)'(doPop);
         end
      end
   end

   // fetch credit count must keep us from overflowing
   assert property (@(posedge clk1) disable iff (!reset)
                    doPush |-> count < (ptrBits+1)'(depth))
      else $error("instrQueue: push while full");

endmodule

`default_nettype wire

//--- design/executeUnit.sv
`include "cardiac_config.svh"
`timescale 1ns/1ps
`default_nettype none

module executeUnit
   import cardiacPkg::*;
(
   input  wire logic                          clk1,
   input  wire logic                          reset,
   input  wire logic                          start,
   input  wire logic                          notEmpty,
   input  wire instrEntry_t                   popEntry,
   output logic                               pop,
   output logic [`CARDIAC_ADDR_BITS-1:0]      execAddr,
   output logic                               execWrite,
   output cardiacWord_t                       execWrData,
   input  wire cardiacWord_t                  execRdData,
   input  wire cardiacWord_t                  inData,
   output logic                               outValid,
   output cardiacWord_t                       outData,
   output logic                               redirect,
   output logic [`CARDIAC_ADDR_BITS-1:0]      redirectAddr,
   output logic                               halted
);

   execState_t state;
   instrEntry_t instr;   // instruction being run
   accWord_t acc;
   accWord_t operand;    // memory word widened to four digits
   accWord_t aluResult;  // acc +/- operand
   accWord_t shifted;    // acc after SFT
   logic [15:0] shiftLeft;
   logic branchTaken;

   // four digit BCD add, carry out of the top is lost
   function automatic logic [15:0] bcdAdd(input logic [15:0] a, input logic [15:0] b);
      logic [15:0] sum;
      logic [4:0] digit;
      logic carry;
      carry = 1'b0;
      sum = '0;
      for (int i = 0; i < 4; i++)
      begin
         digit = {1'b0, a[i*4 +: 4]} + {1'b0, b[i*4 +: 4]} + {4'd0, carry};
         carry = (digit > 5'd9);
         sum[i*4 +: 4] = carry ? 4'(digit - 5'd10) : digit[3:0];
      end
      return sum;
   endfunction

   // a - b, caller guarantees a >= b
   function automatic logic [15:0] bcdSub(input logic [15:0] a, input logic [15:0] b);
      logic [15:0] diff;
      logic [4:0] digit;
      logic borrow;
      borrow = 1'b0;
      diff = '0;
      for (int i = 0; i < 4; i++)
      begin
         digit = {1'b0, a[i*4 +: 4]} + 5'd10 - {1'b0, b[i*4 +: 4]} - {4'd0, borrow};
         borrow = (digit < 5'd10); // needed the ten
         diff[i*4 +: 4] = borrow ? digit[3:0] : 4'(digit - 5'd10);
      end
      return diff;
   endfunction

   // sign-magnitude add; negB turns it into a subtract
   function automatic accWord_t addSigned(input accWord_t a, input accWord_t b, input logic negB);
      accWord_t r;
      logic signB;
      signB = b.sign ^ negB;
      if (a.sign == signB)
      begin
         r.digits = bcdAdd(a.digits, b.digits);
         r.sign = a.sign;
      end
      else if (a.digits >= b.digits) // BCD compares like binary
      begin
         r.digits = bcdSub(a.digits, b.digits);
         r.sign = a.sign;
      end
      else
      begin
         r.digits = bcdSub(b.digits, a.digits);
         r.sign = signB;
      end
      if (r.digits == '0)
         r.sign = 1'b0; // no minus zero
      return r;
   endfunction

   always_comb
   begin
      operand.digits = {4'd0, execRdData.digits};
      operand.sign = execRdData.sign && (execRdData.digits != '0);
      aluResult = addSigned(acc, operand, instr.op == SUB);
      shiftLeft = acc.digits << {instr.addr[7:4], 2'b00};     // tens digit, left
      shifted.digits = shiftLeft >> {instr.addr[3:0], 2'b00}; // units digit, right
      shifted.sign = acc.sign && (shifted.digits != '0);
   end

   assign pop = (state == EXEC_IDLE) && notEmpty && !start;
   assign branchTaken = (state == EXEC_DECODE)
                        && ((instr.op == JMP) || ((instr.op == TAC) && acc.sign));
   assign redirect = start || branchTaken; // start restarts fetch at 00 too
   assign redirectAddr = start ? '0 : instr.addr;
   assign execAddr = instr.addr;
   assign execWrite = (state == EXEC_WRITEBACK); // STO or INP
   assign execWrData = (instr.op == INP) ? inData : {acc.sign, acc.digits[2:0]};
   assign outValid = (state == EXEC_OPERAND) && (instr.op == OUT);
   assign outData = execRdData;
   assign halted = (state == EXEC_HALTED);

   always_ff @(posedge clk1)
   begin
      if (pop)
         instr <= popEntry;
   end

   always_ff @(posedge clk1)
   begin
      if (!reset || start)
      begin
         state <= EXEC_IDLE;
         acc <= '0;
      end
      else
      begin
         case (state)
            EXEC_IDLE:
               if (pop)
                  state <= EXEC_DECODE;
            EXEC_DECODE:
               case (instr.op)
                  CLA, ADD, SUB, OUT: state <= EXEC_OPERAND; // operand read in flight
                  STO, INP: state <= EXEC_WRITEBACK;
                  HRS: state <= EXEC_HALTED;
                  SFT:
                  begin
                     acc <= shifted;
                     state <= EXEC_IDLE;
                  end
                  default: state <= EXEC_IDLE; // TAC, JMP done via redirect
               endcase
            EXEC_OPERAND:
            begin
               if (instr.op == CLA)
                  acc <= operand;
               else if (instr.op != OUT)
                  acc <= aluResult;
               state <= EXEC_IDLE;
            end
            EXEC_WRITEBACK: state <= EXEC_IDLE;
            EXEC_HALTED: state <= EXEC_HALTED; // only start leaves
            default: state <= EXEC_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/cardiacCore.sv
`include "cardiac_config.svh"
`timescale 1ns/1ps
`default_nettype none

module cardiacCore
   import cardiacPkg::*;
(
   input  wire logic                          clk1,
   input  wire logic                          reset,
   input  wire logic                          start,
   input  wire logic                          loadEn,
   input  wire logic [`CARDIAC_ADDR_BITS-1:0] loadAddr,
   input  wire cardiacWord_t                  loadData,
   input  wire cardiacWord_t                  inData,
   output logic                               outValid,
   output cardiacWord_t                       outData,
   output logic                               halted
);

   logic [`CARDIAC_ADDR_BITS-1:0] fetchAddr;
   cardiacWord_t fetchData;
   logic [`CARDIAC_ADDR_BITS-1:0] execAddr;
   logic execWrite;
   cardiacWord_t execWrData;
   cardiacWord_t execRdData;
   logic push;                // fetch -> queue
   instrEntry_t pushEntry;
   logic pop;                 // execute -> queue
   instrEntry_t popEntry;
   logic notEmpty;
   logic creditReturn;        // queue -> fetch
   logic redirect;            // execute -> fetch and queue
   logic [`CARDIAC_ADDR_BITS-1:0] redirectAddr;

   wordMemory wordMemory_i (
      .clk1(clk1), .fetchAddr(fetchAddr), .fetchData(fetchData),
      .execAddr(execAddr), .execWrite(execWrite), .execWrData(execWrData),
      .execRdData(execRdData), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData)
   );

   fetchSequencer fetchSequencer_i (
      .clk1(clk1), .reset(reset), .start(start), .redirect(redirect),
      .redirectAddr(redirectAddr), .creditReturn(creditReturn), .fetchAddr(fetchAddr),
      .fetchData(fetchData), .push(push), .pushEntry(pushEntry)
   );

   instrQueue #(.depth(`CARDIAC_QUEUE_DEPTH)) instrQueue_i (
      .clk1(clk1), .reset(reset), .push(push), .pushEntry(pushEntry), .pop(pop),
      .popEntry(popEntry), .notEmpty(notEmpty), .flush(redirect),
      .creditReturn(creditReturn)
   );

   executeUnit executeUnit_i (
      .clk1(clk1), .reset(reset), .start(start), .notEmpty(notEmpty),
      .popEntry(popEntry), .pop(pop), .execAddr(execAddr), .execWrite(execWrite),
      .execWrData(execWrData), .execRdData(execRdData), .inData(inData),
      .outValid(outValid), .outData(outData), .redirect(redirect),
      .redirectAddr(redirectAddr), .halted(halted)
   );

endmodule

`default_nettype wire

//--- dv/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen
(
   output logic clk1
);

   localparam int halfPeriod = 2; // 4 ns period

   initial
   begin
      clk1 = 1'b0;
      forever
         #halfPeriod clk1 = ~clk1;
   end

endmodule

`default_nettype wire

//--- dv/cardiacTb.sv
`include "cardiac_config.svh"
`timescale 1ns/1ps
`default_nettype none

module cardiacTb
   import cardiacPkg::*;
();

   // about 1200 cycles needed: 4 loads of 100 cells, ~150 instructions at 2..5 cycles
   localparam int maxCycles = 4000;

   logic clk1;
   logic reset;
   logic start;
   logic loadEn;
   logic [`CARDIAC_ADDR_BITS-1:0] loadAddr;
   cardiacWord_t loadData;
   cardiacWord_t inData;
   logic outValid;
   cardiacWord_t outData;
   logic halted;

   cardiacWord_t refMem [`CARDIAC_MEM_WORDS]; // interpreter's own memory
   cardiacWord_t expSeq [512];                // expected OUT words, current run
   int expLen = 0;
   int seen = 0;        // OUT pulses since time zero
   int runBase = 0;     // seen at the start of this run
   int cycleCount = 0;
   bit started = 1'b0;
   logic [31:0] seed = 32'h3297_ece6;

   clockGen clockGen_i (.clk1(clk1));

   cardiacCore cardiacCore_i (
      .clk1(clk1), .reset(reset), .start(start), .loadEn(loadEn), .loadAddr(loadAddr),
      .loadData(loadData), .inData(inData), .outValid(outValid), .outData(outData),
      .halted(halted)
   );

   task automatic failRun(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic cardiacWord_t makeWord(input logic neg, input int mag);
      cardiacWord_t w;
      w.sign = neg;
      w.digits[2] = 4'(mag / 100);
      w.digits[1] = 4'(mag / 10 % 10);
      w.digits[0] = 4'(mag % 10);
      return w;
   endfunction

   function automatic int wordValue(input cardiacWord_t w);
      int mag;
      mag = int'(w.digits[2]) * 100 + int'(w.digits[1]) * 10 + int'(w.digits[0]);
      return w.sign ? -mag : mag; // -000 reads as zero
   endfunction

   // instruction word: opcode digit then two address digits
   function automatic void placeInstr(input int at, input opcode_t op, input int a);
      refMem[at] = makeWord(1'b0, int'(op) * 100 + a);
   endfunction

   // digits past the fourth are lost, sign kept
   function automatic int dropCarry(input int x);
      return (x < 0) ? -((-x) % 10000) : x % 10000;
   endfunction

   function automatic int shiftAcc(input int x, input int left, input int right);
      int mag;
      mag = (x < 0) ? -x : x;
      for (int i = 0; i < left; i++)
         mag = (mag * 10) % 10000; // top digit falls off
      for (int i = 0; i < right; i++)
         mag = mag / 10;
      return (x < 0) ? -mag : mag;
   endfunction

   task automatic fillData();
      logic [31:0] r;
      for (int a = 0; a < `CARDIAC_MEM_WORDS; a++)
      begin
         r = nextRand();
         refMem[a] = makeWord(r[31], int'((r >> 8) % 1000)); // random sign too
      end
   endtask

   // plain CARDIAC semantics over refMem, fills expSeq
   task automatic interpret();
      int pc;
      int acc;
      int a;
      int v;
      int steps;
      bit running;
      opcode_t op;
      pc = 0;
      acc = 0;
      steps = 0;
      running = 1'b1;
      expLen = 0;
      while (running)
      begin
         op = opcode_t'(refMem[pc].digits[2]);
         a = int'(refMem[pc].digits[1]) * 10 + int'(refMem[pc].digits[0]);
         v = wordValue(refMem[a]);
         pc = (pc + 1) % 100; // bug wraps 99 to 00
         case (op)
            INP: refMem[a] = inData;
            CLA: acc = v;
            ADD: acc = dropCarry(acc + v);
            SUB: acc = dropCarry(acc - v);
            TAC: if (acc < 0) pc = a;
            SFT: acc = shiftAcc(acc, a / 10, a % 10); // tens left, units right
            OUT:
            begin
               expSeq[expLen] = refMem[a];
               expLen++;
            end
            STO: refMem[a] = makeWord(acc < 0, ((acc < 0) ? -acc : acc) % 1000);
            JMP: pc = a;
            HRS: running = 1'b0;
            default: failRun("reference model fetched an unknown opcode");
         endcase
         steps++;
         if (steps > 400)
            failRun("reference model ran 400 instructions without reaching HRS");
      end
   endtask

   task automatic loadProgram();
      for (int a = 0; a < `CARDIAC_MEM_WORDS; a++)
      begin
         @(negedge clk1);
         loadEn = 1'b1;
         loadAddr = {4'(a / 10), 4'(a % 10)}; // BCD cell number
         loadData = refMem[a];
      end
      @(negedge clk1);
      loadEn = 1'b0;
   endtask

   task automatic runProgram(input bit fresh);
      if (fresh)
         interpret();
      @(negedge clk1);
      runBase = seen;
      start = 1'b1;
      started = 1'b1;
      @(negedge clk1);
      start = 1'b0;
      while (!halted)
         @(negedge clk1); // cycle watchdog bounds this
      repeat (20)
         @(negedge clk1); // quiet window after HRS
      assert (seen - runBase == expLen)
         else failRun($sformatf("run halted after %0d of %0d expected OUT pulses",
                                seen - runBase, expLen));
   endtask

   task automatic buildArith();
      opcode_t pick [5];
      logic [31:0] r;
      pick = '{CLA, ADD, SUB, STO, OUT};
      fillData();
      for (int i = 0; i < 20; i++)
      begin
         r = nextRand();
         placeInstr(i, pick[(r >> 16) % 5], 50 + int'((r >> 8) % 45)); // data 50..94
      end
      refMem[96] = makeWord(1'b0, 12);
      refMem[97] = makeWord(1'b0, 999);
      placeInstr(20, CLA, 96);
      placeInstr(21, SUB, 97); // 12 - 999, negative
      placeInstr(22, STO, 95);
      placeInstr(23, OUT, 95);
      placeInstr(24, CLA, 97);
      for (int i = 25; i < 35; i++)
         placeInstr(i, ADD, 97); // 11 x 999 runs past four digits
      placeInstr(35, STO, 95);
      placeInstr(36, OUT, 95);
      placeInstr(37, HRS, 0);
   endtask

   task automatic buildShift();
      int pairs [9];
      pairs = '{10, 1, 11, 21, 2, 30, 40, 3, 12}; // left digit, right digit
      fillData();
      refMem[96] = makeWord(1'b1, 100 + int'((nextRand() >> 8) % 900));
      refMem[97] = makeWord(1'b0, 100 + int'((nextRand() >> 8) % 900));
      for (int k = 0; k < 9; k++)
      begin
         placeInstr(4 * k, CLA, (k % 2 != 0) ? 97 : 96);
         placeInstr(4 * k + 1, SFT, pairs[k]);
         placeInstr(4 * k + 2, STO, 95);
         placeInstr(4 * k + 3, OUT, 95);
      end
      placeInstr(36, HRS, 0);
   endtask

   task automatic buildLoop();
      fillData();
      refMem[90] = makeWord(1'b0, 5); // loop counter
      refMem[91] = makeWord(1'b0, 1);
      placeInstr(0, CLA, 90);
      placeInstr(1, SUB, 91);
      placeInstr(2, TAC, 8);  // out once below zero
      placeInstr(3, STO, 90);
      placeInstr(4, OUT, 90);
      placeInstr(5, JMP, 0);
      placeInstr(6, OUT, 91); // prefetched behind JMP, must die in the flush
      placeInstr(7, OUT, 91);
      for (int k = 0; k < 20; k++)
         placeInstr(8 + k, OUT, 70 + k); // queue fills, credits reach zero
      placeInstr(28, HRS, 0);
   endtask

   task automatic buildInput();
      logic [31:0] r;
      fillData();
      r = nextRand();
      @(negedge clk1);
      inData = makeWord(r[31], int'((r >> 8) % 1000)); // held for both runs
      refMem[60] = inData;
      refMem[60].sign = ~inData.sign; // differs from inData until INP lands
      placeInstr(0, INP, 60);
      placeInstr(1, OUT, 60);
      placeInstr(2, HRS, 0);
   endtask

   always @(posedge clk1)
   begin
      cycleCount <= cycleCount + 1;
      if (outValid)
         seen <= seen + 1;
      if (cycleCount == maxCycles)
         failRun("timeout, run still going after the cycle limit");
   end

   // quiet from reset until the first start
   assert property (@(posedge clk1) cycleCount > 0 && !started |-> !outValid && !halted)
      else failRun("outValid or halted went high before the first start");

   // stray OUT after a taken branch or after HRS lands here
   assert property (@(posedge clk1) outValid |-> seen - runBase < expLen)
      else failRun("outValid pulsed with no expected word left");

   // %h shows the sign nibble, then the three BCD digits
   assert property (@(posedge clk1) outValid && seen - runBase < expLen
                    |-> outData == expSeq[seen - runBase])
      else failRun($sformatf("FAIL at %0t outData got %h expected %h", $time,
                             $sampled(outData), expSeq[$sampled(seen) - runBase]));

   assert property (@(posedge clk1) halted && !start |=> halted)
      else failRun("halted dropped without a new start");

   initial
   begin
      reset = 1'b0;
      start = 1'b0;
      loadEn = 1'b0;
      loadAddr = '0;
      loadData = '0;
      inData = '0;
      repeat (10)
         @(negedge clk1);
      reset = 1'b1;
      repeat (20)
         @(negedge clk1); // idle machine, nothing may come out
      buildArith();
      loadProgram();
      runProgram(1'b1);
      buildShift();
      loadProgram();
      runProgram(1'b1);
      buildLoop();
      loadProgram();
      runProgram(1'b1);
      buildInput();
      loadProgram();
      runProgram(1'b1);
      runProgram(1'b0); // second start, same expected words
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
design/cardiacPkg.sv
design/wordMemory.sv
design/fetchSequencer.sv
design/instrQueue.sv
design/executeUnit.sv
design/cardiacCore.sv
dv/clockGen.sv
dv/cardiacTb.sv

//--- run.sh
#!/bin/sh
# builds the CARDIAC testbench with Verilator, runs it, looks for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
      --top-module cardiacTb -f compile.f --Mdir obj_dir -o cardiacSim; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/cardiacSim > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
   echo "simulation passed"
   exit 0
fi

echo "pass line not found in sim.log"
exit 1
